// ==== all.f ====
cft_bus_pkg.sv
microstep_sequencer.sv
read_unit_decoder.sv
write_unit_decoder.sv
bus_register_bank.sv
processor_bus_top.sv
tb_processor_bus.sv

// ==== bus_register_bank.sv ====
// Processor bus register bank
// Bus multiplexer, bus latch and the AR, PC, IR, DR, AC registers

`timescale 1ns/1ps

module bus_register_bank (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    uce_n,
   input  cft_bus_pkg::runit_t     runit,
   input  cft_bus_pkg::rd_strobe_t rd_strobe,
   input  cft_bus_pkg::wr_strobe_t wr_strobe,
   input  cft_bus_pkg::word_t      ext_rd_data,
   output cft_bus_pkg::reg_view_t  regs,
   output logic                    alu_wr_n,
   output cft_bus_pkg::word_t      alu_wr_data
);

   // Live bus value
   cft_bus_pkg::word_t bus;

   // Bus latch holding the read phase word for the write phase
   cft_bus_pkg::word_t bus_latch;

   // Address generation word
   cft_bus_pkg::word_t agl_word;

   // External board owns the bus
   logic ext_sel;

   // Any destination strobe low
   logic wr_any;

   //////////////////////////////
   // Bus sources
   //////////////////////////////

   // Page from PC, offset from IR
   assign agl_word = {regs.pc[15:cft_bus_pkg::AGL_IR_BITS],
                      regs.ir[cft_bus_pkg::AGL_IR_BITS-1:0]};

   // Upper read units belong to the arithmetic board
   // Released along with everything else while the panel holds the bus
   assign ext_sel = runit[cft_bus_pkg::RU_EXT_BIT] & ~uce_n;

   always_comb begin
      // Pull-ups win when nobody drives
      bus = cft_bus_pkg::BUS_IDLE;
      if (!rd_strobe.agl_n) begin
         bus = agl_word;
      end else if (!rd_strobe.pc_n) begin
         bus = regs.pc;
      end else if (!rd_strobe.dr_n) begin
         bus = regs.dr;
      end else if (!rd_strobe.ac_n) begin
         bus = regs.ac;
      end else if (ext_sel) begin
         bus = ext_rd_data;
      end
   end

   //////////////////////////////
   // Bus latch
   //////////////////////////////

   assign wr_any = ~&wr_strobe;

   // Follows the bus until a write strobe opens, then holds
   // Last capture is the edge closing the read phase
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bus_latch <= '0;
      end else if (!wr_any) begin
         bus_latch <= bus;
      end
   end

   //////////////////////////////
   // Registers
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         regs <= '0;
      end else begin
         // Strobed destination loads from the latch
         if (!wr_strobe.ar_n) begin
            regs.ar <= bus_latch;
         end
         if (!wr_strobe.pc_n) begin
            regs.pc <= bus_latch;
         end
         if (!wr_strobe.ir_n) begin
            regs.ir <= bus_latch;
         end
         if (!wr_strobe.dr_n) begin
            regs.dr <= bus_latch;
         end
         if (!wr_strobe.ac_n) begin
            regs.ac <= bus_latch;
         end
      end
   end

   // ALU write goes off board with the latched word
   assign alu_wr_n    = wr_strobe.alu_n;
   assign alu_wr_data = bus_latch;

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Registers hold while every write strobe is released
   a_regs_hold: assert property (@(posedge clk) disable iff (!arst_n)
      !wr_any |-> ##1 $stable(regs));

endmodule

// ==== bus_stim.txt ====
// runit wunit ext_rd_data uce_n | expected: alu_wr_n alu_wr_data ar pc ir dr ac
// All values hex, one microstep per line
8 2 1234 0 1 0000 1234 0000 0000 0000 0000
9 3 a5c3 0 1 0000 1234 a5c3 0000 0000 0000
a 4 3f0f 0 1 0000 1234 a5c3 3f0f 0000 0000
b 5 00ff 0 1 0000 1234 a5c3 3f0f 00ff 0000
f 6 8001 0 1 0000 1234 a5c3 3f0f 00ff 8001
3 2 dead 0 1 0000 a5c3 a5c3 3f0f 00ff 8001
2 5 0000 0 1 0000 a5c3 a5c3 3f0f a70f 8001
5 4 0000 0 1 0000 a5c3 a5c3 8001 a70f 8001
4 6 0000 0 1 0000 a5c3 a5c3 8001 a70f a70f
2 3 0000 0 1 0000 a5c3 a401 8001 a70f a70f
3 5 0000 0 1 0000 a5c3 a401 8001 a401 a70f
0 6 1357 0 1 0000 a5c3 a401 8001 a401 ffff
1 2 0000 0 1 0000 ffff a401 8001 a401 ffff
6 4 0000 0 1 0000 ffff a401 ffff a401 ffff
7 5 0000 0 1 0000 ffff a401 ffff ffff ffff
c 0 0f0f 0 1 0000 ffff a401 ffff ffff ffff
3 1 0000 0 1 0000 ffff a401 ffff ffff ffff
d 6 5a5a 0 1 0000 ffff a401 ffff ffff 5a5a
5 7 0000 0 0 5a5a ffff a401 ffff ffff 5a5a
e 7 c0de 0 0 c0de ffff a401 ffff ffff 5a5a
2 7 0000 0 0 a7ff ffff a401 ffff ffff 5a5a
8 2 1111 1 1 0000 ffff a401 ffff ffff 5a5a
3 7 0000 1 1 0000 ffff a401 ffff ffff 5a5a
0 6 0000 1 1 0000 ffff a401 ffff ffff 5a5a
9 5 2468 0 1 0000 ffff a401 ffff 2468 5a5a
4 2 0000 0 1 0000 2468 a401 ffff 2468 5a5a

// ==== cft_bus_pkg.sv ====
// Processor bus definitions shared by the microstep datapath
// Word, unit number and strobe types, plus the unit encodings

package cft_bus_pkg;

   //////////////////////////////
   // Basic types
   //////////////////////////////

   // Processor bus word
   typedef logic [15:0] word_t;

   // Read unit number whose bit 3 hands the source to the external board
   typedef logic [3:0] runit_t;

   // Write unit number
   typedef logic [2:0] wunit_t;

   // Bit of the read unit that selects the external arithmetic board
   localparam int RU_EXT_BIT = 3;

   // Address generation joins upper PC to lower IR at this split
   localparam int AGL_IR_BITS = 10;

   //////////////////////////////
   // Bundles
   //////////////////////////////

   // One microstep, carried by the step handshake
   typedef struct packed {
      runit_t runit;
      wunit_t wunit;
   } microstep_t;

   // Source strobes, all active low
   typedef struct packed {
      logic agl_n;
      logic pc_n;
      logic dr_n;
      logic ac_n;
   } rd_strobe_t;

   // Destination strobes, all active low
   typedef struct packed {
      logic ar_n;
      logic pc_n;
      logic ir_n;
      logic dr_n;
      logic ac_n;
      logic alu_n;
   } wr_strobe_t;

   // Visible register state
   typedef struct packed {
      word_t ar;
      word_t pc;
      word_t ir;
      word_t dr;
      word_t ac;
   } reg_view_t;

   //////////////////////////////
   // Unit encodings
   //////////////////////////////

   // Read units decoded on this board (0, 1, 6, 7 unused)
   localparam runit_t RU_AGL = 4'd2;
   localparam runit_t RU_PC  = 4'd3;
   localparam runit_t RU_DR  = 4'd4;
   localparam runit_t RU_AC  = 4'd5;

   // Write units (0, 1 unused)
   localparam wunit_t WU_AR  = 3'd2;
   localparam wunit_t WU_PC  = 3'd3;
   localparam wunit_t WU_IR  = 3'd4;
   localparam wunit_t WU_DR  = 3'd5;
   localparam wunit_t WU_AC  = 3'd6;
   localparam wunit_t WU_ALU = 3'd7;

   // Pulled-up bus value with no source driving
   localparam word_t BUS_IDLE = 16'hffff;

   // Strobe sets with nothing selected
   localparam rd_strobe_t RD_IDLE = '1;
   localparam wr_strobe_t WR_IDLE = '1;

endpackage

// ==== microstep_sequencer.sv ====
// Microstep sequencer
// Four-phase req/ack slave that runs one read phase and one write phase per step

`timescale 1ns/1ps

module microstep_sequencer (
   input  logic clk,
   input  logic arst_n,
   input  logic step_req,
   output logic step_ack,
   output logic read_phase,
   output logic write_phase
);

   // Step states
   typedef enum logic [1:0] {
      S_IDLE  = 2'd0,
      S_READ  = 2'd1,
      S_WRITE = 2'd2,
      S_ACK   = 2'd3
   } state_t;

   state_t state;
   state_t state_nxt;

   //////////////////////////////
   // Next state
   //////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         // Wait for a request, and for the last ack to be gone
         S_IDLE:  if (step_req && !step_ack) state_nxt = S_READ;
         S_READ:  state_nxt = S_WRITE;
         S_WRITE: state_nxt = S_ACK;
         // Hold until the master drops its request
         S_ACK:   if (!step_req) state_nxt = S_IDLE;
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   //////////////////////////////
   // Registered phase outputs
   //////////////////////////////

   // Outputs trail the state by one clock so the decoders see clean phases
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         read_phase  <= 1'b0;
         write_phase <= 1'b0;
         step_ack    <= 1'b0;
      end else begin
         read_phase  <= (state == S_READ);
         write_phase <= (state == S_WRITE);
         step_ack    <= (state == S_ACK);
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Read and write never overlap
   a_phase_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(read_phase && write_phase));

   // Ack only answers a request still live at the edge that raised it
   a_ack_on_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(step_ack) |-> $past(step_req));

endmodule

// ==== processor_bus_top.sv ====
// Processor bus top level
// Sequencer, read and write decoders and the register bank wired together

`timescale 1ns/1ps

module processor_bus_top (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   step_req,
   input  cft_bus_pkg::microstep_t step,
   input  cft_bus_pkg::word_t     ext_rd_data,
   input  logic                   uce_n,
   output logic                   step_ack,
   output cft_bus_pkg::reg_view_t regs,
   output logic                   alu_wr_n,
   output cft_bus_pkg::word_t     alu_wr_data
);

   // Phase pulses from the sequencer
   logic read_phase;
   logic write_phase;

   // Decoded strobe sets
   cft_bus_pkg::rd_strobe_t rd_strobe;
   cft_bus_pkg::wr_strobe_t wr_strobe;

   //////////////////////////////
   // Step handshake
   //////////////////////////////

   microstep_sequencer seq0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .step_req    (step_req),
      .step_ack    (step_ack),
      .read_phase  (read_phase),
      .write_phase (write_phase)
   );

   //////////////////////////////
   // Decoders side by side
   //////////////////////////////

   read_unit_decoder rdec0 (
      .arst_n     (arst_n),
      .read_phase (read_phase),
      .uce_n      (uce_n),
      .runit      (step.runit),
      .rd_strobe  (rd_strobe)
   );

   write_unit_decoder wdec0 (
      .arst_n      (arst_n),
      .write_phase (write_phase),
      .uce_n       (uce_n),
      .wunit       (step.wunit),
      .wr_strobe   (wr_strobe)
   );

   // Bank combines both strobe sets into the transfer
   bus_register_bank bank0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .uce_n       (uce_n),
      .runit       (step.runit),
      .rd_strobe   (rd_strobe),
      .wr_strobe   (wr_strobe),
      .ext_rd_data (ext_rd_data),
      .regs        (regs),
      .alu_wr_n    (alu_wr_n),
      .alu_wr_data (alu_wr_data)
   );

endmodule

// ==== read_unit_decoder.sv ====
// Read unit decoder
// Turns the read unit into active-low source strobes during the read phase

`timescale 1ns/1ps

module read_unit_decoder (
   input  logic                    arst_n,
   input  logic                    read_phase,
   input  logic                    uce_n,
   input  cft_bus_pkg::runit_t     runit,
   output cft_bus_pkg::rd_strobe_t rd_strobe
);

   // Decoder enable
   logic rd_en;

   // Only units 0..7 live here as the upper half is the external board
   // Front panel holding the bus (uce_n high) releases every strobe
   assign rd_en = arst_n & read_phase & ~runit[cft_bus_pkg::RU_EXT_BIT] & ~uce_n;

   //////////////////////////////
   // Unit decode
   //////////////////////////////

   always_comb begin
      rd_strobe = cft_bus_pkg::RD_IDLE;
      if (rd_en) begin
         case (runit)
            // Address generation source
            cft_bus_pkg::RU_AGL: rd_strobe.agl_n = 1'b0;
            cft_bus_pkg::RU_PC:  rd_strobe.pc_n  = 1'b0;
            cft_bus_pkg::RU_DR:  rd_strobe.dr_n  = 1'b0;
            cft_bus_pkg::RU_AC:  rd_strobe.ac_n  = 1'b0;
            // Units 0, 1, 6, 7 leave the bus to the pull-ups
            default: rd_strobe = cft_bus_pkg::RD_IDLE;
         endcase
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // A single source on the bus at any time
   always_comb begin
      assert ($onehot0(~rd_strobe))
         else $error("read_unit_decoder: more than one source strobe low");
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the processor bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_processor_bus -f all.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1

// ==== tb_processor_bus.sv ====
// Processor bus testbench
// Runs each stim line as one microstep handshake and checks registers and ALU write

`timescale 1ns/1ps

module tb_processor_bus;

   // Stim layout of 26 lines with 11 hex words each
   localparam int NUM_STEPS  = 26;
   localparam int STEP_WORDS = 11;
   localparam int WAIT_LIMIT = 20;

   logic                   clk;
   logic                   arst_n;
   logic                   step_req;
   cft_bus_pkg::microstep_t step;
   cft_bus_pkg::word_t     ext_rd_data;
   logic                   uce_n;
   logic                   step_ack;
   cft_bus_pkg::reg_view_t regs;
   logic                   alu_wr_n;
   cft_bus_pkg::word_t     alu_wr_data;

   logic [15:0] stim_mem [0:NUM_STEPS*STEP_WORDS-1];

   // Reference model of the visible state
   cft_bus_pkg::reg_view_t model_regs;
   logic                   model_alu_n;
   cft_bus_pkg::word_t     model_alu_data;

   int cur_step;
   int mismatches;
   int timeouts;

   processor_bus_top dut0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .step_req    (step_req),
      .step        (step),
      .ext_rd_data (ext_rd_data),
      .uce_n       (uce_n),
      .step_ack    (step_ack),
      .regs        (regs),
      .alu_wr_n    (alu_wr_n),
      .alu_wr_data (alu_wr_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("** Error: step %0d %s got %h expected %h", cur_step, name, got, exp);
      end
   endtask

   task automatic compare_regs(input string tag, input cft_bus_pkg::reg_view_t exp);
      check_value({"regs.ar ", tag}, regs.ar, exp.ar);
      check_value({"regs.pc ", tag}, regs.pc, exp.pc);
      check_value({"regs.ir ", tag}, regs.ir, exp.ir);
      check_value({"regs.dr ", tag}, regs.dr, exp.dr);
      check_value({"regs.ac ", tag}, regs.ac, exp.ac);
   endtask

   // Bus source and then destination as the board transfers one word
   task automatic model_step(input logic [3:0] ru, input logic [2:0] wu,
                             input logic [15:0] ext, input logic uce);
      logic [15:0] bus;
      bus = cft_bus_pkg::BUS_IDLE;
      model_alu_n = 1'b1;
      model_alu_data = '0;
      // Nothing moves while the panel owns the bus
      if (!uce) begin
         if (ru[3]) begin
            bus = ext;
         end else begin
            case (ru)
               cft_bus_pkg::RU_AGL: bus = {model_regs.pc[15:10], model_regs.ir[9:0]};
               cft_bus_pkg::RU_PC:  bus = model_regs.pc;
               cft_bus_pkg::RU_DR:  bus = model_regs.dr;
               cft_bus_pkg::RU_AC:  bus = model_regs.ac;
               default:             bus = cft_bus_pkg::BUS_IDLE;
            endcase
         end
         case (wu)
            cft_bus_pkg::WU_AR: model_regs.ar = bus;
            cft_bus_pkg::WU_PC: model_regs.pc = bus;
            cft_bus_pkg::WU_IR: model_regs.ir = bus;
            cft_bus_pkg::WU_DR: model_regs.dr = bus;
            cft_bus_pkg::WU_AC: model_regs.ac = bus;
            cft_bus_pkg::WU_ALU: begin
               model_alu_n = 1'b0;
               model_alu_data = bus;
            end
            default: ;
         endcase
      end
   endtask

   // One full four-phase handshake for stim line idx
   task automatic run_step(input int idx, output logic timed_out);
      int base;
      int cnt;
      int alu_cnt;
      logic seen_alu_n;
      logic [15:0] seen_alu_data;
      base = idx * STEP_WORDS;
      cnt = 0;
      alu_cnt = 0;
      seen_alu_n = 1'b1;
      seen_alu_data = '0;
      timed_out = 1'b0;
      cur_step = idx + 1;
      step.runit = stim_mem[base][3:0];
      step.wunit = stim_mem[base+1][2:0];
      ext_rd_data = stim_mem[base+2];
      uce_n = stim_mem[base+3][0];
      step_req = 1'b1;
      model_step(step.runit, step.wunit, ext_rd_data, uce_n);
      // Wait for the ack to rise and watch for the ALU pulse on the way
      while (!step_ack && cnt < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         cnt++;
         if (!alu_wr_n) begin
            seen_alu_n = 1'b0;
            seen_alu_data = alu_wr_data;
            alu_cnt = cnt;
         end
      end
      if (!step_ack) begin
         timeouts++;
         timed_out = 1'b1;
         $display("Timeout: step_ack never rose during step %0d", cur_step);
      end else begin
         // First count is the edge that samples the request
         check_value("step_ack rise cycles", 16'(cnt - 1), 16'd3);
         compare_regs("(model)", model_regs);
         compare_regs("(stim)", {stim_mem[base+6], stim_mem[base+7], stim_mem[base+8],
                                 stim_mem[base+9], stim_mem[base+10]});
         check_value("alu_wr_n (model)", {15'd0, seen_alu_n}, {15'd0, model_alu_n});
         check_value("alu_wr_n (stim)", {15'd0, seen_alu_n}, stim_mem[base+4]);
         if (!model_alu_n) begin
            check_value("alu_wr_data (model)", seen_alu_data, model_alu_data);
            check_value("alu_wr_data (stim)", seen_alu_data, stim_mem[base+5]);
            // Pulse sits in the write phase
            check_value("alu_wr_n cycle", 16'(alu_cnt), 16'd3);
         end
         step_req = 1'b0;
         cnt = 0;
         while (step_ack && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cnt++;
         end
         if (step_ack) begin
            timeouts++;
            timed_out = 1'b1;
            $display("Timeout: step_ack never fell during step %0d", cur_step);
         end else begin
            check_value("step_ack fall cycles", 16'(cnt - 1), 16'd1);
         end
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      logic timed_out;
      arst_n = 1'b0;
      step_req = 1'b0;
      step = '0;
      ext_rd_data = '0;
      uce_n = 1'b0;
      model_regs = '0;
      model_alu_n = 1'b1;
      model_alu_data = '0;
      cur_step = 0;
      mismatches = 0;
      timeouts = 0;
      timed_out = 1'b0;
      $readmemh("bus_stim.txt", stim_mem);
      repeat (10) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(posedge clk);
      #1;
      // Reset state before any step
      compare_regs("(reset)", model_regs);
      check_value("alu_wr_n", {15'd0, alu_wr_n}, 16'd1);
      check_value("step_ack", {15'd0, step_ack}, 16'd0);
      for (int i = 0; i < NUM_STEPS && !timed_out; i++) begin
         run_step(i, timed_out);
      end
      $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== write_unit_decoder.sv ====
// Write unit decoder
// Turns the write unit into active-low destination strobes in the write phase

`timescale 1ns/1ps

module write_unit_decoder (
   input  logic                    arst_n,
   input  logic                    write_phase,
   input  logic                    uce_n,
   input  cft_bus_pkg::wunit_t     wunit,
   output cft_bus_pkg::wr_strobe_t wr_strobe
);

   // Decoder enable
   logic wr_en;

   // Same gating as the read side, applied to the write phase
   assign wr_en = arst_n & write_phase & ~uce_n;

   //////////////////////////////
   // Unit decode
   //////////////////////////////

   always_comb begin
      wr_strobe = cft_bus_pkg::WR_IDLE;
      if (wr_en) begin
         case (wunit)
            cft_bus_pkg::WU_AR:  wr_strobe.ar_n  = 1'b0;
            cft_bus_pkg::WU_PC:  wr_strobe.pc_n  = 1'b0;
            cft_bus_pkg::WU_IR:  wr_strobe.ir_n  = 1'b0;
            cft_bus_pkg::WU_DR:  wr_strobe.dr_n  = 1'b0;
            cft_bus_pkg::WU_AC:  wr_strobe.ac_n  = 1'b0;
            // Result goes out to the arithmetic board
            cft_bus_pkg::WU_ALU: wr_strobe.alu_n = 1'b0;
            // Units 0 and 1 write nowhere
            default: wr_strobe = cft_bus_pkg::WR_IDLE;
         endcase
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Destinations are one-cold or fully released
   always_comb begin
      assert ($onehot0(~wr_strobe))
         else $error("write_unit_decoder: more than one destination strobe low");
   end

endmodule
